// ==== run.sh ====
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f \
    --top-module tb_reservation_station -Mdir obj_dir -o sim_rs
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rs > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== sources.f ====
verilog/rs_pkg.sv
verilog/rs_entry.sv
verilog/rs_alloc.sv
verilog/rs_issue_select.sv
verilog/reservation_station.sv
testbench/reservation_station_props.sv
testbench/tb_reservation_station.sv

// ==== testbench/reservation_station_props.sv ====
// Reservation station properties
// Grants only to ready units, issue ports carry their own type,
// and the station accepts dispatch right after reset

`timescale 1ns/1ps

module reservation_station_props
    import rs_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic      [FU_NUM-1:0]    fu_ready_i,
    input  logic      [FU_NUM-1:0]    issue_valid_o,
    input  rs_entry_t [FU_NUM-1:0]    issue_entry_o,
    input  logic                      disp_ready_o,
    input  logic      [RS_DEPTH-1:0]  slot_grant,
    input  rs_entry_t [RS_DEPTH-1:0]  slot_entry
);

    // A slot is only released to a unit that accepts
    for (genvar s = 0; s < RS_DEPTH; s++) begin : g_grant
        a_grant_ready: assert property (@(posedge clock) disable iff (reset)
            slot_grant[s] |-> fu_ready_i[slot_entry[s].fu_type])
            else $error("slot %0d granted to a stalled unit", s);
    end

    // Port index equals unit type
    for (genvar f = 0; f < FU_NUM; f++) begin : g_port
        a_port_type: assert property (@(posedge clock) disable iff (reset)
            issue_valid_o[f] |-> (issue_entry_o[f].fu_type == fu_type_t'(f)))
            else $error("issue port %0d carries a wrong unit type", f);
    end

    // Empty station after reset
    a_ready_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> disp_ready_o)
        else $error("disp_ready_o low after reset");

endmodule

bind reservation_station reservation_station_props u_props (
    .clock         (clock),
    .reset         (reset),
    .fu_ready_i    (fu_ready_i),
    .issue_valid_o (issue_valid_o),
    .issue_entry_o (issue_entry_o),
    .disp_ready_o  (disp_ready_o),
    .slot_grant    (slot_grant),
    .slot_entry    (slot_entry)
);

// ==== testbench/tb_reservation_station.sv ====
// Reservation station testbench
// Directed tests against a slot-array reference model that predicts
// disp_ready_o and the issue ports every cycle

`timescale 1ns/1ps

module tb_reservation_station
    import rs_pkg::*;
;

    // ========================================
    // Run constants
    // ========================================
    localparam int CLK_PERIOD   = 40;
    localparam int SEED         = 91070;
    localparam int RESET_CYCLES = 2;
    // Test lengths summed in cycles plus a margin
    localparam int TEST_CYCLES  = 62;
    localparam int MARGIN       = 60;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD;

    logic                            clock;
    logic                            reset;
    logic                            disp_valid_i;
    rs_entry_t                       disp_entry_i;
    logic                            disp_spec_i;
    logic                            disp_ready_o;
    logic [CDB_WIDTH-1:0]            cdb_valid_i;
    logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i;
    logic      [FU_NUM-1:0]          fu_ready_i;
    logic      [FU_NUM-1:0]          issue_valid_o;
    rs_entry_t [FU_NUM-1:0]          issue_entry_o;
    logic                            br_resolve_i;
    logic                            br_mispredict_i;

    int errors = 0;

    // Reference model state
    logic [RS_DEPTH-1:0] m_empty;
    logic [RS_DEPTH-1:0] m_spec;
    rs_entry_t           m_entry [RS_DEPTH];

    reservation_station dut (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_entry_i    (disp_entry_i),
        .disp_spec_i     (disp_spec_i),
        .disp_ready_o    (disp_ready_o),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_tag_i       (cdb_tag_i),
        .fu_ready_i      (fu_ready_i),
        .issue_valid_o   (issue_valid_o),
        .issue_entry_o   (issue_entry_o),
        .br_resolve_i    (br_resolve_i),
        .br_mispredict_i (br_mispredict_i)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ========================================
    // Reference model
    // ========================================
    // Lowest ready slot of unit f or -1 when none
    function automatic int pick_slot(input int f);
        int idx;
        idx = -1;
        for (int s = RS_DEPTH - 1; s >= 0; s--) begin
            if (!m_empty[s] && m_entry[s].src1_ready && m_entry[s].src2_ready
                && (m_entry[s].fu_type == fu_type_t'(f))) begin
                idx = s;
            end
        end
        return idx;
    endfunction

    task automatic update_model();
        logic [RS_DEPTH-1:0] grant;
        int                  sel;
        int                  free;
        grant = '0;
        free  = -1;
        for (int f = 0; f < FU_NUM; f++) begin
            sel = pick_slot(f);
            if (sel >= 0 && fu_ready_i[f]) begin
                grant[sel] = 1'b1;
            end
        end
        for (int s = RS_DEPTH - 1; s >= 0; s--) begin
            if (m_empty[s]) begin
                free = s;
            end
        end
        for (int s = 0; s < RS_DEPTH; s++) begin
            if (br_mispredict_i && !m_empty[s] && m_spec[s]
                && (m_entry[s].fu_type != FU_BRANCH)) begin
                // Wrong-path instruction dropped
                m_empty[s] = 1'b1;
                m_spec[s]  = 1'b0;
            end else if (disp_valid_i && disp_entry_i.valid && (free == s)) begin
                m_entry[s]        = disp_entry_i;
                m_entry[s].br_tag = disp_spec_i;
                m_empty[s]        = 1'b0;
                m_spec[s]         = disp_spec_i;
            end else begin
                if (br_resolve_i) begin
                    m_entry[s].br_tag = 1'b0;
                    m_spec[s]         = 1'b0;
                end
                for (int k = 0; k < CDB_WIDTH; k++) begin
                    if (cdb_valid_i[k] && (cdb_tag_i[k] == m_entry[s].src1_tag)) begin
                        m_entry[s].src1_ready = 1'b1;
                    end
                    if (cdb_valid_i[k] && (cdb_tag_i[k] == m_entry[s].src2_tag)) begin
                        m_entry[s].src2_ready = 1'b1;
                    end
                end
                if (grant[s]) begin
                    m_empty[s] = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            m_empty = '1;
            m_spec  = '0;
            for (int s = 0; s < RS_DEPTH; s++) begin
                m_entry[s] = '0;
            end
        end else begin
            update_model();
        end
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_entry(input string what, input rs_entry_t got, input rs_entry_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Model versus DUT on every port the model predicts
    task automatic compare_outputs();
        int sel;
        check_bit("disp_ready_o", disp_ready_o, |m_empty);
        for (int f = 0; f < FU_NUM; f++) begin
            sel = pick_slot(f);
            check_bit($sformatf("issue_valid_o[%0d]", f), issue_valid_o[f], sel >= 0);
            if (sel >= 0) begin
                check_entry($sformatf("issue_entry_o[%0d]", f), issue_entry_o[f], m_entry[sel]);
            end
        end
    endtask

    // ========================================
    // Stimulus helpers
    // ========================================
    // Outputs settle on the rising edge and are checked at the falling one
    task automatic tick();
        @(negedge clock);
        compare_outputs();
    endtask

    function automatic rs_entry_t make_entry(input fu_type_t fu,
                                             input logic [TAG_W-1:0] src1, input logic rdy1,
                                             input logic [TAG_W-1:0] src2, input logic rdy2,
                                             input int rob);
        rs_entry_t e;
        e.valid      = 1'b1;
        e.fu_type    = fu;
        e.dest_tag   = TAG_W'(rob + 8);
        e.src1_tag   = src1;
        e.src1_ready = rdy1;
        e.src2_tag   = src2;
        e.src2_ready = rdy2;
        e.rob_idx    = ROB_W'(rob);
        e.br_tag     = 1'b0;
        return e;
    endfunction

    task automatic dispatch(input rs_entry_t e, input logic spec);
        disp_valid_i = 1'b1;
        disp_entry_i = e;
        disp_spec_i  = spec;
        tick();
        disp_valid_i = 1'b0;
        disp_spec_i  = 1'b0;
    endtask

    // Lets every ready unit drain the station
    task automatic drain(input int cycles);
        fu_ready_i = '1;
        repeat (cycles) tick();
        check_bit("disp_ready_o after drain", disp_ready_o, 1'b1);
    endtask

    task automatic broadcast(input int lane, input logic [TAG_W-1:0] tag);
        cdb_valid_i[lane] = 1'b1;
        cdb_tag_i[lane]   = tag;
        tick();
        cdb_valid_i = '0;
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_ready_issue();
        fu_ready_i = '0;
        dispatch(make_entry(FU_ALU, '0, 1'b1, '0, 1'b1, 1), 1'b0);
        check_bit("ALU valid after dispatch", issue_valid_o[FU_ALU], 1'b1);
        tick();
        fu_ready_i[FU_ALU] = 1'b1;
        tick();
        check_bit("ALU valid after accept", issue_valid_o[FU_ALU], 1'b0);
        drain(2);
    endtask

    task automatic test_wakeup();
        logic [TAG_W-1:0] t1;
        logic [TAG_W-1:0] t2;
        t1 = TAG_W'($urandom);
        t2 = t1 + TAG_W'(1 + $urandom_range(0, 60));
        fu_ready_i = '1;
        // Same-cycle broadcast of t1 is missed by the new entry
        cdb_valid_i[0] = 1'b1;
        cdb_tag_i[0]   = t1;
        dispatch(make_entry(FU_LOAD, t1, 1'b0, t2, 1'b0, 3), 1'b0);
        cdb_valid_i = '0;
        tick();
        check_bit("LOAD waiting on both", issue_valid_o[FU_LOAD], 1'b0);
        broadcast(1, t2);
        check_bit("LOAD waiting on src1", issue_valid_o[FU_LOAD], 1'b0);
        broadcast(0, t1);
        check_bit("LOAD woken", issue_valid_o[FU_LOAD], 1'b1);
        drain(2);
    endtask

    task automatic test_backpressure();
        rs_entry_t first;
        // Slot 0 takes the first MUL of the burst
        first      = make_entry(FU_MUL, '0, 1'b1, '0, 1'b1, 10);
        fu_ready_i = '0;
        for (int i = 0; i <= RS_DEPTH; i++) begin
            dispatch(make_entry(FU_MUL, '0, 1'b1, '0, 1'b1, 10 + i), 1'b0);
        end
        check_bit("disp_ready_o when full", disp_ready_o, 1'b0);
        check_entry("MUL port when full", issue_entry_o[FU_MUL], first);
        repeat (2) begin
            tick();
            check_entry("MUL held under stall", issue_entry_o[FU_MUL], first);
        end
        // One MUL per cycle in lowest-slot order
        fu_ready_i[FU_MUL] = 1'b1;
        repeat (RS_DEPTH) tick();
        drain(1);
    endtask

    task automatic test_parallel();
        fu_ready_i = '0;
        dispatch(make_entry(FU_ALU, '0, 1'b1, '0, 1'b1, 20), 1'b0);
        dispatch(make_entry(FU_MUL, '0, 1'b1, '0, 1'b1, 21), 1'b0);
        dispatch(make_entry(FU_LOAD, '0, 1'b1, '0, 1'b1, 22), 1'b0);
        dispatch(make_entry(FU_BRANCH, '0, 1'b1, '0, 1'b1, 23), 1'b0);
        fu_ready_i = '1;
        tick();
        check_bit("all units issued together", |issue_valid_o, 1'b0);
        drain(1);
    endtask

    task automatic test_mispredict();
        logic [TAG_W-1:0] tw;
        tw = TAG_W'($urandom);
        fu_ready_i = '0;
        dispatch(make_entry(FU_ALU, tw, 1'b0, '0, 1'b1, 24), 1'b0);
        dispatch(make_entry(FU_ALU, tw, 1'b0, '0, 1'b1, 25), 1'b1);
        dispatch(make_entry(FU_MUL, tw, 1'b0, '0, 1'b1, 26), 1'b1);
        dispatch(make_entry(FU_LOAD, tw, 1'b0, '0, 1'b1, 27), 1'b1);
        dispatch(make_entry(FU_BRANCH, tw, 1'b0, '0, 1'b1, 28), 1'b1);
        for (int i = 0; i < 3; i++) begin
            dispatch(make_entry(FU_ALU, tw, 1'b0, '0, 1'b1, 29 + i), 1'b0);
        end
        check_bit("disp_ready_o before flush", disp_ready_o, 1'b0);
        br_mispredict_i = 1'b1;
        tick();
        br_mispredict_i = 1'b0;
        check_bit("disp_ready_o after flush", disp_ready_o, 1'b1);
        broadcast(0, tw);
        check_bit("branch kept", issue_valid_o[FU_BRANCH], 1'b1);
        check_bit("MUL flushed", issue_valid_o[FU_MUL], 1'b0);
        drain(6);
    endtask

    task automatic test_resolve();
        logic [TAG_W-1:0] tw;
        tw = TAG_W'($urandom);
        fu_ready_i = '0;
        dispatch(make_entry(FU_ALU, '0, 1'b1, tw, 1'b0, 4), 1'b1);
        dispatch(make_entry(FU_MUL, '0, 1'b1, tw, 1'b0, 5), 1'b1);
        dispatch(make_entry(FU_LOAD, '0, 1'b1, tw, 1'b0, 6), 1'b1);
        br_resolve_i = 1'b1;
        tick();
        br_resolve_i    = 1'b0;
        br_mispredict_i = 1'b1;
        tick();
        br_mispredict_i = 1'b0;
        broadcast(1, tw);
        check_bit("ALU survived", issue_valid_o[FU_ALU], 1'b1);
        check_bit("MUL survived", issue_valid_o[FU_MUL], 1'b1);
        check_bit("LOAD survived", issue_valid_o[FU_LOAD], 1'b1);
        drain(2);
    endtask

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        disp_valid_i    = 1'b0;
        disp_entry_i    = '0;
        disp_spec_i     = 1'b0;
        cdb_valid_i     = '0;
        cdb_tag_i       = '0;
        fu_ready_i      = '0;
        br_resolve_i    = 1'b0;
        br_mispredict_i = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        tick();
        test_ready_issue();
        test_wakeup();
        test_backpressure();
        test_parallel();
        test_mispredict();
        test_resolve();
        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog/reservation_station.sv ====
// Reservation station top level
// Eight tag-only slots with lowest-free allocation, dual-lane CDB
// wakeup, one issue per functional unit and one level of speculation

`timescale 1ns/1ps

module reservation_station
    import rs_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // Dispatch
    input  logic                            disp_valid_i,
    input  rs_entry_t                       disp_entry_i,
    input  logic                            disp_spec_i,
    output logic                            disp_ready_o,

    // Result bus
    input  logic [CDB_WIDTH-1:0]            cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,

    // Issue, one port per unit
    input  logic      [FU_NUM-1:0]          fu_ready_i,
    output logic      [FU_NUM-1:0]          issue_valid_o,
    output rs_entry_t [FU_NUM-1:0]          issue_entry_o,

    // Branch outcome
    input  logic                            br_resolve_i,
    input  logic                            br_mispredict_i
);

    // ========================================
    // Slot array wiring
    // ========================================
    logic      [RS_DEPTH-1:0] slot_empty;
    logic      [RS_DEPTH-1:0] slot_ready;
    rs_entry_t [RS_DEPTH-1:0] slot_entry;
    logic      [RS_DEPTH-1:0] slot_disp_en;
    logic      [RS_DEPTH-1:0] slot_grant;

    // Allocation of the incoming instruction
    rs_alloc u_alloc (
        .disp_valid_i       (disp_valid_i),
        .disp_entry_valid_i (disp_entry_i.valid),
        .slot_empty_i       (slot_empty),
        .disp_en_o          (slot_disp_en),
        .disp_ready_o       (disp_ready_o)
    );

    // Slots, broadcast buses shared by all
    for (genvar s = 0; s < RS_DEPTH; s++) begin : g_slot
        rs_entry u_entry (
            .clock           (clock),
            .reset           (reset),
            .disp_en_i       (slot_disp_en[s]),
            .disp_entry_i    (disp_entry_i),
            .disp_spec_i     (disp_spec_i),
            .issue_grant_i   (slot_grant[s]),
            .cdb_valid_i     (cdb_valid_i),
            .cdb_tag_i       (cdb_tag_i),
            .br_resolve_i    (br_resolve_i),
            .br_mispredict_i (br_mispredict_i),
            .empty_o         (slot_empty[s]),
            .ready_o         (slot_ready[s]),
            .entry_o         (slot_entry[s])
        );
    end

    // Per-unit pick and grant back to slots
    rs_issue_select u_select (
        .slot_ready_i  (slot_ready),
        .slot_entry_i  (slot_entry),
        .fu_ready_i    (fu_ready_i),
        .issue_valid_o (issue_valid_o),
        .issue_entry_o (issue_entry_o),
        .issue_grant_o (slot_grant)
    );

endmodule

// ==== verilog/rs_alloc.sv ====
// Dispatch allocator
// Priority encoder over empty slots, lowest index first,
// producing a single write strobe and the not-full level

`timescale 1ns/1ps

module rs_alloc
    import rs_pkg::*;
(
    input  logic                disp_valid_i,
    input  logic                disp_entry_valid_i,
    input  logic [RS_DEPTH-1:0] slot_empty_i,
    output logic [RS_DEPTH-1:0] disp_en_o,
    output logic                disp_ready_o
);

    // Lowest empty slot
    logic              free_found;
    logic [SLOT_W-1:0] free_idx;

    // ========================================
    // Priority encode
    // ========================================
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        // Walk down so the lowest index is the last write
        for (int s = RS_DEPTH - 1; s >= 0; s--) begin
            if (slot_empty_i[s]) begin
                free_found = 1'b1;
                free_idx   = SLOT_W'(s);
            end
        end
    end

    // One-hot strobe only on a real dispatch
    always_comb begin
        disp_en_o = '0;
        if (disp_valid_i && disp_entry_valid_i && free_found) begin
            disp_en_o[free_idx] = 1'b1;
        end
    end

    // Not full
    assign disp_ready_o = free_found;

endmodule

// ==== verilog/rs_entry.sv ====
// Reservation station slot
// Holds one instruction from dispatch until issue, wakes its sources
// from the result bus and tracks one level of branch speculation

`timescale 1ns/1ps

module rs_entry
    import rs_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // Dispatch side
    input  logic                            disp_en_i,
    input  rs_entry_t                       disp_entry_i,
    input  logic                            disp_spec_i,

    // Issue side
    input  logic                            issue_grant_i,

    // Result bus
    input  logic [CDB_WIDTH-1:0]            cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,

    // Branch outcome broadcast
    input  logic                            br_resolve_i,
    input  logic                            br_mispredict_i,

    // Slot state
    output logic                            empty_o,
    output logic                            ready_o,
    output rs_entry_t                       entry_o
);

    // ========================================
    // State
    // ========================================
    rs_entry_t  entry_q, entry_d;
    logic       empty_q, empty_d;
    logic       spec_q, spec_d;

    // Tag matches on any lane
    logic       src1_hit;
    logic       src2_hit;

    // Slot is a wrong-path victim this cycle
    logic       flush_hit;

    // ========================================
    // CDB wakeup compare
    // ========================================
    always_comb begin
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            // Both sources checked against every live lane
            if (cdb_valid_i[k] && (cdb_tag_i[k] == entry_q.src1_tag)) begin
                src1_hit = 1'b1;
            end
            if (cdb_valid_i[k] && (cdb_tag_i[k] == entry_q.src2_tag)) begin
                src2_hit = 1'b1;
            end
        end
    end

    // Branches themselves survive a mispredict
    assign flush_hit = br_mispredict_i && !empty_q && spec_q
                       && (entry_q.fu_type != FU_BRANCH);

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        entry_d = entry_q;
        empty_d = empty_q;
        spec_d  = spec_q;

        if (flush_hit) begin
            // Wrong path, drop it, wins over a grant
            empty_d = 1'b1;
            spec_d  = 1'b0;
        end else if (disp_en_i && empty_q && disp_entry_i.valid) begin
            // Capture as given, same-cycle CDB not merged
            entry_d        = disp_entry_i;
            entry_d.br_tag = disp_spec_i;
            empty_d        = 1'b0;
            spec_d         = disp_spec_i;
        end else begin
            // Branch went the predicted way
            if (br_resolve_i) begin
                entry_d.br_tag = 1'b0;
                spec_d         = 1'b0;
            end

            // Sticky source readiness
            entry_d.src1_ready = entry_q.src1_ready | src1_hit;
            entry_d.src2_ready = entry_q.src2_ready | src2_hit;

            // Leaves once the unit takes it
            if (issue_grant_i && ready_o) begin
                empty_d = 1'b1;
            end
        end
    end

    // Control state
    always_ff @(posedge clock) begin
        if (reset) begin
            empty_q <= 1'b1;
            spec_q  <= 1'b0;
        end else begin
            empty_q <= empty_d;
            spec_q  <= spec_d;
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        entry_q <= entry_d;
    end

    // ========================================
    // Outputs
    // ========================================
    assign empty_o = empty_q;
    // Registered state only, no CDB bypass
    assign ready_o = !empty_q && entry_q.src1_ready && entry_q.src2_ready;
    assign entry_o = entry_q;

endmodule

// ==== verilog/rs_issue_select.sv ====
// Issue selector
// For each functional unit picks the lowest ready slot of that unit's
// type, drives the issue port and grants the slot when the unit accepts

`timescale 1ns/1ps

module rs_issue_select
    import rs_pkg::*;
(
    input  logic      [RS_DEPTH-1:0] slot_ready_i,
    input  rs_entry_t [RS_DEPTH-1:0] slot_entry_i,
    input  logic      [FU_NUM-1:0]   fu_ready_i,
    output logic      [FU_NUM-1:0]   issue_valid_o,
    output rs_entry_t [FU_NUM-1:0]   issue_entry_o,
    output logic      [RS_DEPTH-1:0] issue_grant_o
);

    // Ready and of the right type, per unit per slot
    logic [FU_NUM-1:0][RS_DEPTH-1:0] cand;

    // Winner per unit
    logic [FU_NUM-1:0]             sel_hit;
    logic [FU_NUM-1:0][SLOT_W-1:0] sel_idx;

    // ========================================
    // Candidate matrix
    // ========================================
    always_comb begin
        for (int f = 0; f < FU_NUM; f++) begin
            for (int s = 0; s < RS_DEPTH; s++) begin
                cand[f][s] = slot_ready_i[s]
                             && (slot_entry_i[s].fu_type == fu_type_t'(f));
            end
        end
    end

    // ========================================
    // Lowest-slot pick per unit
    // ========================================
    always_comb begin
        for (int f = 0; f < FU_NUM; f++) begin
            sel_hit[f] = 1'b0;
            sel_idx[f] = '0;
            // Descending walk, lowest candidate ends up selected
            for (int s = RS_DEPTH - 1; s >= 0; s--) begin
                if (cand[f][s]) begin
                    sel_hit[f] = 1'b1;
                    sel_idx[f] = SLOT_W'(s);
                end
            end
        end
    end

    // ========================================
    // Issue ports and grants
    // ========================================
    always_comb begin
        issue_grant_o = '0;
        for (int f = 0; f < FU_NUM; f++) begin
            // Valid regardless of unit readiness
            issue_valid_o[f] = sel_hit[f];
            issue_entry_o[f] = slot_entry_i[sel_idx[f]];
            // Types are disjoint, so at most one grant per slot
            if (sel_hit[f] && fu_ready_i[f]) begin
                issue_grant_o[sel_idx[f]] = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/rs_pkg.sv ====
// Reservation station shared definitions
// Sizes, functional-unit encoding and the slot payload layout
// used by the slot, allocator, issue selector and top level

package rs_pkg;

    // ========================================
    // Sizes
    // ========================================
    // Physical register file and tag width
    localparam int PHYS_REGS = 64;
    localparam int TAG_W     = $clog2(PHYS_REGS);

    // Result bus lanes
    localparam int CDB_WIDTH = 2;

    // Station depth and slot index width
    localparam int RS_DEPTH  = 8;
    localparam int SLOT_W    = $clog2(RS_DEPTH);

    // ROB index width, 32 entries
    localparam int ROB_W     = 5;

    // One issue port per unit
    localparam int FU_NUM    = 4;

    // ========================================
    // Functional unit type
    // ========================================
    // Value doubles as the issue port index
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_LOAD   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_t;

    // ========================================
    // Slot payload
    // ========================================
    // Tags only, operand values live outside the station
    typedef struct packed {
        // Instruction present in the packet
        logic               valid;
        // Target unit
        fu_type_t           fu_type;
        // Rename of the destination
        logic [TAG_W-1:0]   dest_tag;
        // First source and its wakeup state
        logic [TAG_W-1:0]   src1_tag;
        logic               src1_ready;
        // Second source and its wakeup state
        logic [TAG_W-1:0]   src2_tag;
        logic               src2_ready;
        // Position in the ROB
        logic [ROB_W-1:0]   rob_idx;
        // Follows the unresolved branch
        logic               br_tag;
    } rs_entry_t;

endpackage
